// ==== logic/ebox_settings.svh ====
`ifndef EBOX_SETTINGS_SVH
`define EBOX_SETTINGS_SVH

// Data word and halfword, bit 0 is the sign
`define EBOX_WORD 36
`define EBOX_HALF 18

// Fast memory, one AC block
`define EBOX_FM_DEPTH 16
`define EBOX_FM_ADR 4

// Microword
`define EBOX_CRAM_WIDTH 24

// AD function code width in the package type
`define EBOX_AD_FUNC_W 4

// Width of the two-bit select types
`define EBOX_SEL_W 2

`endif

// ==== logic/eboxPkg.sv ====
`include "ebox_settings.svh"

package eboxPkg;

  // AD/ADX function, microword field is three bits wide
  typedef enum logic [0:`EBOX_AD_FUNC_W-1] {
    aPlusB,
    aMinusB,
    aAndB,
    aOrB,
    aXorB,
    passA,
    passB,
    aPlusOne
  } adFuncT;

  typedef enum logic [0:`EBOX_SEL_W-1] {
    adaAr,
    adaArx,
    adaMq,
    adaZero
  } adaSelT;

  // Shifted BR fills from BRX, shifted AR fills from ARX
  typedef enum logic [0:`EBOX_SEL_W-1] {
    adbFm,
    adbBr,
    adbBrX2,
    adbArX4
  } adbSelT;

  typedef enum logic [0:`EBOX_SEL_W-1] {
    arHold,
    arAd,
    arCache,
    arEbus
  } arSelT;

  typedef enum logic [0:`EBOX_SEL_W-1] {
    mqHold,
    mqLoadAd,
    mqShl,
    mqShr
  } mqFuncT;

  // Same order as the diagnostic read function codes
  typedef enum logic [0:2] {
    diagAr,
    diagBr,
    diagMq,
    diagFm,
    diagBrx,
    diagArx,
    diagAdx,
    diagAd
  } diagSelT;

endpackage

// ==== logic/cramDecode.sv ====
`include "ebox_settings.svh"

module cramDecode (
  input  logic                          eboxClk,
  input  logic                          rstN,
  input  logic                          step,
  input  logic [0:`EBOX_CRAM_WIDTH-1]   cram,
  output eboxPkg::adFuncT               adFunc,
  output eboxPkg::adaSelT               adaSel,
  output eboxPkg::adbSelT               adbSel,
  output eboxPkg::arSelT                arSel,
  output logic                          arxLoad,
  output logic                          brLoad,
  output logic                          brxLoad,
  output eboxPkg::mqFuncT               mqFunc,
  output logic [0:1]                    fmWrite,
  output logic [0:`EBOX_FM_ADR-1]       fmAdr,
  output logic                          adLong,
  output logic                          adToEbus
);

  logic runEn;
  logic go;

  // EBOX does no work on the edge that ends reset
  always_ff @(posedge eboxClk) begin
    if (!rstN) begin
      runEn <= 1'b0;
    end else begin
      runEn <= 1'b1;
    end
  end

  assign go = step && runEn;

  // Adder steering changes no state, so it follows the microword always
  assign adFunc = eboxPkg::adFuncT'({1'b0, cram[0:2]});
  assign adaSel = eboxPkg::adaSelT'(cram[3:4]);
  assign adbSel = eboxPkg::adbSelT'(cram[5:6]);
  assign fmAdr  = cram[16:19];
  assign adLong = cram[20];

  // Bits 22 and 23 are spare
  always_comb begin
    arSel    = eboxPkg::arHold;
    arxLoad  = 1'b0;
    brLoad   = 1'b0;
    brxLoad  = 1'b0;
    mqFunc   = eboxPkg::mqHold;
    fmWrite  = 2'b00;
    adToEbus = 1'b0;
    if (go) begin
      arSel    = eboxPkg::arSelT'(cram[7:8]);
      arxLoad  = cram[9];
      brLoad   = cram[10];
      brxLoad  = cram[11];
      mqFunc   = eboxPkg::mqFuncT'(cram[12:13]);
      fmWrite  = cram[14:15];
      adToEbus = cram[21];
    end
  end

endmodule

// ==== logic/fastMem.sv ====
`include "ebox_settings.svh"

module fastMem (
  input  logic                      eboxClk,
  input  logic [0:`EBOX_FM_ADR-1]   adr,
  input  logic [0:`EBOX_WORD-1]     din,
  input  logic [0:1]                we,
  output logic [0:`EBOX_WORD-1]     dout
);

  logic [0:`EBOX_WORD-1] mem [0:`EBOX_FM_DEPTH-1];

  // we[0] is the left half, bits 0-17
  always_ff @(posedge eboxClk) begin
    if (we[0]) begin
      mem[adr][0:`EBOX_HALF-1] <= din[0:`EBOX_HALF-1];
    end
    if (we[1]) begin
      mem[adr][`EBOX_HALF:`EBOX_WORD-1] <= din[`EBOX_HALF:`EBOX_WORD-1];
    end
  end

  // Asynchronous read
  assign dout = mem[adr];

endmodule

// ==== logic/adderUnit.sv ====
`include "ebox_settings.svh"

module adderUnit (
  input  eboxPkg::adFuncT           adFunc,
  input  logic [0:`EBOX_WORD-1]     ada,
  input  logic [0:`EBOX_WORD-1]     adb,
  input  logic [0:`EBOX_WORD-1]     adxa,
  input  logic [0:`EBOX_WORD-1]     adxb,
  input  logic                      adLong,
  output logic [0:`EBOX_WORD-1]     ad,
  output logic [0:`EBOX_WORD-1]     adx,
  output logic                      adCarry,
  output logic                      adOverflow
);

  logic                  arith;
  logic                  linked;
  logic                  baseCin;
  logic                  adCin;
  logic [0:`EBOX_WORD-1] adbEff;
  logic [0:`EBOX_WORD-1] adxbEff;
  // Bit 0 of a sum is the carry out of the word
  logic [0:`EBOX_WORD]   adSum;
  logic [0:`EBOX_WORD]   adxSum;

  always_comb begin
    arith  = adFunc inside {eboxPkg::aPlusB, eboxPkg::aMinusB, eboxPkg::aPlusOne};
    linked = adLong && (adFunc inside {eboxPkg::aPlusB, eboxPkg::aMinusB});

    // Subtract is A plus not B plus one
    unique case (adFunc)
      eboxPkg::aMinusB: begin
        adbEff  = ~adb;
        adxbEff = ~adxb;
      end
      eboxPkg::aPlusOne: begin
        adbEff  = '0;
        adxbEff = '0;
      end
      default: begin
        adbEff  = adb;
        adxbEff = adxb;
      end
    endcase
    baseCin = (adFunc == eboxPkg::aMinusB) || (adFunc == eboxPkg::aPlusOne);

    // ADX first, its carry out is the AD carry in for long operations
    adxSum = {1'b0, adxa} + {1'b0, adxbEff} + {{`EBOX_WORD{1'b0}}, baseCin};
    adCin  = linked ? adxSum[0] : baseCin;
    adSum  = {1'b0, ada} + {1'b0, adbEff} + {{`EBOX_WORD{1'b0}}, adCin};

    unique case (adFunc)
      eboxPkg::aAndB: begin
        ad  = ada & adb;
        adx = adxa & adxb;
      end
      eboxPkg::aOrB: begin
        ad  = ada | adb;
        adx = adxa | adxb;
      end
      eboxPkg::aXorB: begin
        ad  = ada ^ adb;
        adx = adxa ^ adxb;
      end
      eboxPkg::passA: begin
        ad  = ada;
        adx = adxa;
      end
      eboxPkg::passB: begin
        ad  = adb;
        adx = adxb;
      end
      default: begin
        ad  = adSum[1:`EBOX_WORD];
        adx = adxSum[1:`EBOX_WORD];
      end
    endcase

    adCarry    = arith && adSum[0];
    // Like signs in, other sign out
    adOverflow = arith && (ada[0] == adbEff[0]) && (adSum[1] != ada[0]);
  end

endmodule

// ==== logic/edpRegs.sv ====
`include "ebox_settings.svh"

module edpRegs (
  input  logic                      eboxClk,
  input  logic                      rstN,
  input  eboxPkg::adFuncT           adFunc,
  input  eboxPkg::adaSelT           adaSel,
  input  eboxPkg::adbSelT           adbSel,
  input  eboxPkg::arSelT            arSel,
  input  logic                      arxLoad,
  input  logic                      brLoad,
  input  logic                      brxLoad,
  input  eboxPkg::mqFuncT           mqFunc,
  input  logic [0:1]                fmWrite,
  input  logic [0:`EBOX_FM_ADR-1]   fmAdr,
  input  logic                      adLong,
  input  logic [0:`EBOX_WORD-1]     cacheData,
  input  logic [0:`EBOX_WORD-1]     ebusIn,
  output logic [0:`EBOX_WORD-1]     ar,
  output logic [0:`EBOX_WORD-1]     arx,
  output logic [0:`EBOX_WORD-1]     br,
  output logic [0:`EBOX_WORD-1]     brx,
  output logic [0:`EBOX_WORD-1]     mq,
  output logic [0:`EBOX_WORD-1]     fm,
  output logic [0:`EBOX_WORD-1]     ad,
  output logic [0:`EBOX_WORD-1]     adx,
  output logic                      adCarry,
  output logic                      adOverflow
);

  logic [0:`EBOX_WORD-1] ada;
  logic [0:`EBOX_WORD-1] adb;

  always_comb begin
    unique case (adaSel)
      eboxPkg::adaAr:  ada = ar;
      eboxPkg::adaArx: ada = arx;
      eboxPkg::adaMq:  ada = mq;
      default:         ada = '0;
    endcase

    // Shifted sources pick up the top bits of the low word
    unique case (adbSel)
      eboxPkg::adbFm:   adb = fm;
      eboxPkg::adbBr:   adb = br;
      eboxPkg::adbBrX2: adb = {br[1:`EBOX_WORD-1], brx[0]};
      default:          adb = {ar[2:`EBOX_WORD-1], arx[0:1]};
    endcase
  end

  always_ff @(posedge eboxClk) begin
    if (!rstN) begin
      ar  <= '0;
      arx <= '0;
      br  <= '0;
      brx <= '0;
      mq  <= '0;
    end else begin
      unique case (arSel)
        eboxPkg::arAd:    ar <= ad;
        eboxPkg::arCache: ar <= cacheData;
        eboxPkg::arEbus:  ar <= ebusIn;
        default:          ar <= ar;
      endcase
      if (arxLoad) begin
        arx <= ad;
      end
      if (brLoad) begin
        br <= ar;
      end
      if (brxLoad) begin
        brx <= arx;
      end
      // MQ shifts left taking the AD carry, right copying the sign
      unique case (mqFunc)
        eboxPkg::mqLoadAd: mq <= ad;
        eboxPkg::mqShl:    mq <= {mq[1:`EBOX_WORD-1], adCarry};
        eboxPkg::mqShr:    mq <= {mq[0], mq[0:`EBOX_WORD-2]};
        default:           mq <= mq;
      endcase
    end
  end

  fastMem fmRam (
    .eboxClk (eboxClk),
    .adr     (fmAdr),
    .din     (ar),
    .we      (fmWrite),
    .dout    (fm)
  );

  adderUnit adder (
    .adFunc     (adFunc),
    .ada        (ada),
    .adb        (adb),
    .adxa       (arx),
    .adxb       (brx),
    .adLong     (adLong),
    .ad         (ad),
    .adx        (adx),
    .adCarry    (adCarry),
    .adOverflow (adOverflow)
  );

endmodule

// ==== logic/ebusDriver.sv ====
`include "ebox_settings.svh"

module ebusDriver (
  input  logic                      eboxClk,
  input  logic                      rstN,
  input  logic                      diagRead,
  input  eboxPkg::diagSelT          diagSel,
  input  logic                      adToEbus,
  input  logic [0:`EBOX_WORD-1]     ar,
  input  logic [0:`EBOX_WORD-1]     br,
  input  logic [0:`EBOX_WORD-1]     mq,
  input  logic [0:`EBOX_WORD-1]     fm,
  input  logic [0:`EBOX_WORD-1]     brx,
  input  logic [0:`EBOX_WORD-1]     arx,
  input  logic [0:`EBOX_WORD-1]     adx,
  input  logic [0:`EBOX_WORD-1]     ad,
  output logic [0:`EBOX_WORD-1]     ebusData,
  output logic                      ebusDriving
);

  logic [0:`EBOX_WORD-1] ebusNext;

  // AD to EBUS overrides any diagnostic select
  always_comb begin
    ebusNext = '0;
    if (adToEbus) begin
      ebusNext = ad;
    end else if (diagRead) begin
      unique case (diagSel)
        eboxPkg::diagAr:  ebusNext = ar;
        eboxPkg::diagBr:  ebusNext = br;
        eboxPkg::diagMq:  ebusNext = mq;
        eboxPkg::diagFm:  ebusNext = fm;
        eboxPkg::diagBrx: ebusNext = brx;
        eboxPkg::diagArx: ebusNext = arx;
        eboxPkg::diagAdx: ebusNext = adx;
        default:          ebusNext = ad;
      endcase
    end
  end

  // Bus reads as zero when nobody drives it
  always_ff @(posedge eboxClk) begin
    if (!rstN) begin
      ebusDriving <= 1'b0;
      ebusData    <= '0;
    end else begin
      ebusDriving <= diagRead || adToEbus;
      ebusData    <= ebusNext;
    end
  end

endmodule

// ==== logic/eboxDataPath.sv ====
`include "ebox_settings.svh"

module eboxDataPath (
  input  logic                          eboxClk,
  input  logic                          rstN,
  input  logic                          step,
  input  logic [0:`EBOX_CRAM_WIDTH-1]   cram,
  input  logic [0:`EBOX_WORD-1]         cacheData,
  input  logic [0:`EBOX_WORD-1]         ebusIn,
  input  logic                          diagRead,
  input  eboxPkg::diagSelT              diagSel,
  output logic [0:`EBOX_WORD-1]         ar,
  output logic [0:`EBOX_WORD-1]         arx,
  output logic [0:`EBOX_WORD-1]         br,
  output logic [0:`EBOX_WORD-1]         brx,
  output logic [0:`EBOX_WORD-1]         mq,
  output logic [0:`EBOX_WORD-1]         ad,
  output logic                          adCarry,
  output logic                          adOverflow,
  output logic [0:`EBOX_WORD-1]         ebusData,
  output logic                          ebusDriving
);

  eboxPkg::adFuncT         adFunc;
  eboxPkg::adaSelT         adaSel;
  eboxPkg::adbSelT         adbSel;
  eboxPkg::arSelT          arSel;
  eboxPkg::mqFuncT         mqFunc;
  logic                    arxLoad;
  logic                    brLoad;
  logic                    brxLoad;
  logic [0:1]              fmWrite;
  logic [0:`EBOX_FM_ADR-1] fmAdr;
  logic                    adLong;
  logic                    adToEbus;
  logic [0:`EBOX_WORD-1]   fm;
  logic [0:`EBOX_WORD-1]   adx;

  cramDecode decode (
    .eboxClk  (eboxClk),
    .rstN     (rstN),
    .step     (step),
    .cram     (cram),
    .adFunc   (adFunc),
    .adaSel   (adaSel),
    .adbSel   (adbSel),
    .arSel    (arSel),
    .arxLoad  (arxLoad),
    .brLoad   (brLoad),
    .brxLoad  (brxLoad),
    .mqFunc   (mqFunc),
    .fmWrite  (fmWrite),
    .fmAdr    (fmAdr),
    .adLong   (adLong),
    .adToEbus (adToEbus)
  );

  edpRegs execute (
    .eboxClk    (eboxClk),
    .rstN       (rstN),
    .adFunc     (adFunc),
    .adaSel     (adaSel),
    .adbSel     (adbSel),
    .arSel      (arSel),
    .arxLoad    (arxLoad),
    .brLoad     (brLoad),
    .brxLoad    (brxLoad),
    .mqFunc     (mqFunc),
    .fmWrite    (fmWrite),
    .fmAdr      (fmAdr),
    .adLong     (adLong),
    .cacheData  (cacheData),
    .ebusIn     (ebusIn),
    .ar         (ar),
    .arx        (arx),
    .br         (br),
    .brx        (brx),
    .mq         (mq),
    .fm         (fm),
    .ad         (ad),
    .adx        (adx),
    .adCarry    (adCarry),
    .adOverflow (adOverflow)
  );

  ebusDriver result (
    .eboxClk     (eboxClk),
    .rstN        (rstN),
    .diagRead    (diagRead),
    .diagSel     (diagSel),
    .adToEbus    (adToEbus),
    .ar          (ar),
    .br          (br),
    .mq          (mq),
    .fm          (fm),
    .brx         (brx),
    .arx         (arx),
    .adx         (adx),
    .ad          (ad),
    .ebusData    (ebusData),
    .ebusDriving (ebusDriving)
  );

endmodule

// ==== tests/eboxClockGen.sv ====
module eboxClockGen (
  output logic eboxClk
);

  // 40 unit period
  initial begin
    eboxClk = 1'b0;
  end

  always begin
    #20;
    eboxClk = ~eboxClk;
  end

endmodule

// ==== tests/eboxTb.sv ====
`include "ebox_settings.svh"

module eboxTb;

  localparam int randomSteps = 200;
  // Directed part is about 140 cycles
  localparam int testCycles = randomSteps + 140;

  // AD function codes
  localparam logic [0:2] fnAdd = 3'd0;
  localparam logic [0:2] fnSub = 3'd1;
  localparam logic [0:2] fnPassA = 3'd5;
  localparam logic [0:2] fnPassB = 3'd6;
  localparam logic [0:2] fnInc = 3'd7;
  localparam logic [0:1] arCache = 2'd2;
  // AR plus BR with nothing loaded
  localparam logic [0:`EBOX_CRAM_WIDTH-1] idleWord = {3'd0, 2'd0, 2'd1, 17'd0};

  logic                        eboxClk;
  logic                        rstN;
  logic                        step;
  logic [0:`EBOX_CRAM_WIDTH-1] cram;
  logic [0:`EBOX_WORD-1]       cacheData;
  logic [0:`EBOX_WORD-1]       ebusIn;
  logic                        diagRead;
  eboxPkg::diagSelT            diagSel;
  logic [0:`EBOX_WORD-1]       ar;
  logic [0:`EBOX_WORD-1]       arx;
  logic [0:`EBOX_WORD-1]       br;
  logic [0:`EBOX_WORD-1]       brx;
  logic [0:`EBOX_WORD-1]       mq;
  logic [0:`EBOX_WORD-1]       ad;
  logic                        adCarry;
  logic                        adOverflow;
  logic [0:`EBOX_WORD-1]       ebusData;
  logic                        ebusDriving;

  // Shadow copies of the data path state
  logic [0:`EBOX_WORD-1]       sAr;
  logic [0:`EBOX_WORD-1]       sArx;
  logic [0:`EBOX_WORD-1]       sBr;
  logic [0:`EBOX_WORD-1]       sBrx;
  logic [0:`EBOX_WORD-1]       sMq;
  logic [0:`EBOX_WORD-1]       sFm [0:`EBOX_FM_DEPTH-1];
  logic [0:`EBOX_WORD-1]       expEbus;
  logic                        expDriving;
  logic                        checking;
  int                          failures;
  integer                      seed;

  eboxClockGen clockGen (
    .eboxClk (eboxClk)
  );

  eboxDataPath DUT (
    .eboxClk     (eboxClk),
    .rstN        (rstN),
    .step        (step),
    .cram        (cram),
    .cacheData   (cacheData),
    .ebusIn      (ebusIn),
    .diagRead    (diagRead),
    .diagSel     (diagSel),
    .ar          (ar),
    .arx         (arx),
    .br          (br),
    .brx         (brx),
    .mq          (mq),
    .ad          (ad),
    .adCarry     (adCarry),
    .adOverflow  (adOverflow),
    .ebusData    (ebusData),
    .ebusDriving (ebusDriving)
  );

  function automatic logic [0:`EBOX_WORD-1] rand36();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[35:0];
  endfunction

  // Loads are {arxLoad, brLoad, brxLoad}
  function automatic logic [0:`EBOX_CRAM_WIDTH-1] makeWord(
    input logic [0:2] fn,
    input logic [0:1] adaS,
    input logic [0:1] adbS,
    input logic [0:1] arS,
    input logic [0:2] loads,
    input logic [0:1] mqF,
    input logic [0:1] fmW,
    input logic [0:3] fmA,
    input logic       lng,
    input logic       toEb
  );
    return {fn, adaS, adbS, arS, loads, mqF, fmW, fmA, lng, toEb, 2'b00};
  endfunction

  // Expected {carry, overflow, AD, ADX} from the shadow state
  function automatic logic [0:73] refAdder(input logic [0:`EBOX_CRAM_WIDTH-1] uw);
    logic [0:`EBOX_WORD-1] a;
    logic [0:`EBOX_WORD-1] b;
    logic [0:`EBOX_WORD-1] bEff;
    logic [0:`EBOX_WORD-1] xbEff;
    logic [0:`EBOX_WORD-1] adV;
    logic [0:`EBOX_WORD-1] adxV;
    logic [0:72]           wide;
    logic [0:36]           hi;
    logic [0:36]           lo;
    logic                  sub;
    logic                  cy;
    logic                  ov;
    case (uw[3:4])
      2'd0: a = sAr;
      2'd1: a = sArx;
      2'd2: a = sMq;
      default: a = '0;
    endcase
    case (uw[5:6])
      2'd0: b = sFm[uw[16:19]];
      2'd1: b = sBr;
      2'd2: b = {sBr[1:35], sBrx[0]};
      default: b = {sAr[2:35], sArx[0:1]};
    endcase
    sub = (uw[0:2] == fnSub);
    bEff = sub ? ~b : b;
    xbEff = sub ? ~sBrx : sBrx;
    cy = 1'b0;
    ov = 1'b0;
    case (uw[0:2])
      fnAdd, fnSub: begin
        // Long mode is one 72-bit sum of AD over ADX
        wide = {1'b0, a, sArx} + {1'b0, bEff, xbEff} + {72'd0, sub};
        hi = {1'b0, a} + {1'b0, bEff} + {36'd0, sub};
        lo = {1'b0, sArx} + {1'b0, xbEff} + {36'd0, sub};
        if (uw[20]) begin
          hi = wide[0:36];
        end
        cy = hi[0];
        adV = hi[1:36];
        adxV = lo[1:36];
        ov = (a[0] == bEff[0]) && (adV[0] != a[0]);
      end
      fnInc: begin
        hi = {1'b0, a} + 37'd1;
        lo = {1'b0, sArx} + 37'd1;
        cy = hi[0];
        adV = hi[1:36];
        adxV = lo[1:36];
        ov = !a[0] && adV[0];
      end
      3'd2: begin
        adV = a & b;
        adxV = sArx & sBrx;
      end
      3'd3: begin
        adV = a | b;
        adxV = sArx | sBrx;
      end
      3'd4: begin
        adV = a ^ b;
        adxV = sArx ^ sBrx;
      end
      fnPassA: begin
        adV = a;
        adxV = sArx;
      end
      default: begin
        adV = b;
        adxV = sBrx;
      end
    endcase
    return {cy, ov, adV, adxV};
  endfunction

  task automatic checkValue(
    input string                 name,
    input logic [0:`EBOX_WORD-1] got,
    input logic [0:`EBOX_WORD-1] exp
  );
    if (got !== exp) begin
      failures++;
      $display("ERR %s got %h expected %h", name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // Drive one cycle at the falling edge, then advance the shadow state
  task automatic applyCycle(
    input logic                        st,
    input logic [0:`EBOX_CRAM_WIDTH-1] uw,
    input logic [0:`EBOX_WORD-1]       cd,
    input logic                        dr,
    input logic [0:2]                  ds
  );
    logic [0:73]           res;
    logic [0:`EBOX_WORD-1] adV;
    logic                  toEbus;
    @(negedge eboxClk);
    step = st;
    cram = uw;
    cacheData = cd;
    ebusIn = rand36();
    diagRead = dr;
    diagSel = eboxPkg::diagSelT'(ds);
    res = refAdder(uw);
    adV = res[2:37];
    toEbus = st && uw[21];
    expDriving = dr || toEbus;
    if (toEbus) begin
      expEbus = adV;
    end else if (dr) begin
      case (ds)
        3'd0: expEbus = sAr;
        3'd1: expEbus = sBr;
        3'd2: expEbus = sMq;
        3'd3: expEbus = sFm[uw[16:19]];
        3'd4: expEbus = sBrx;
        3'd5: expEbus = sArx;
        3'd6: expEbus = res[38:73];
        default: expEbus = adV;
      endcase
    end else begin
      expEbus = '0;
    end
    // Old AR and ARX feed FM, BR and BRX, so they update first
    if (st) begin
      if (uw[14]) begin
        sFm[uw[16:19]][0:17] = sAr[0:17];
      end
      if (uw[15]) begin
        sFm[uw[16:19]][18:35] = sAr[18:35];
      end
      case (uw[12:13])
        2'd1: sMq = adV;
        2'd2: sMq = {sMq[1:35], res[0]};
        2'd3: sMq = {sMq[0], sMq[0:34]};
        default: sMq = sMq;
      endcase
      if (uw[11]) begin
        sBrx = sArx;
      end
      if (uw[10]) begin
        sBr = sAr;
      end
      if (uw[9]) begin
        sArx = adV;
      end
      case (uw[7:8])
        2'd1: sAr = adV;
        2'd2: sAr = cd;
        2'd3: sAr = ebusIn;
        default: sAr = sAr;
      endcase
    end
  endtask

  // Leaves BR = x and AR = y
  task automatic loadArBr(input logic [0:`EBOX_WORD-1] x, input logic [0:`EBOX_WORD-1] y);
    applyCycle(1'b1, makeWord(fnAdd, 2'd0, 2'd1, arCache, 3'b000, 2'd0, 2'd0, 4'd0, 1'b0, 1'b0),
               x, 1'b0, 3'd0);
    applyCycle(1'b1, makeWord(fnAdd, 2'd0, 2'd1, arCache, 3'b010, 2'd0, 2'd0, 4'd0, 1'b0, 1'b0),
               y, 1'b0, 3'd0);
  endtask

  task automatic runArith();
    applyCycle(1'b1, makeWord(fnAdd, 2'd0, 2'd1, 2'd0, 3'b000, 2'd0, 2'd0, 4'd0, 1'b0, 1'b0),
               rand36(), 1'b0, 3'd0);
    applyCycle(1'b1, makeWord(fnSub, 2'd0, 2'd1, 2'd0, 3'b000, 2'd0, 2'd0, 4'd0, 1'b0, 1'b0),
               rand36(), 1'b0, 3'd0);
    applyCycle(1'b1, makeWord(fnInc, 2'd0, 2'd1, 2'd0, 3'b000, 2'd0, 2'd0, 4'd0, 1'b0, 1'b0),
               rand36(), 1'b0, 3'd0);
  endtask

  // AR, BR over ARX, BRX, then long add, long subtract, short add
  task automatic runLong(
    input logic [0:`EBOX_WORD-1] hiA,
    input logic [0:`EBOX_WORD-1] hiB,
    input logic [0:`EBOX_WORD-1] loA,
    input logic [0:`EBOX_WORD-1] loB
  );
    applyCycle(1'b1, makeWord(fnAdd, 2'd0, 2'd1, arCache, 3'b000, 2'd0, 2'd0, 4'd0, 1'b0, 1'b0),
               loB, 1'b0, 3'd0);
    applyCycle(1'b1, makeWord(fnPassA, 2'd0, 2'd1, arCache, 3'b100, 2'd0, 2'd0, 4'd0, 1'b0, 1'b0),
               loA, 1'b0, 3'd0);
    applyCycle(1'b1, makeWord(fnPassA, 2'd0, 2'd1, arCache, 3'b101, 2'd0, 2'd0, 4'd0, 1'b0, 1'b0),
               hiB, 1'b0, 3'd0);
    applyCycle(1'b1, makeWord(fnAdd, 2'd0, 2'd1, arCache, 3'b010, 2'd0, 2'd0, 4'd0, 1'b0, 1'b0),
               hiA, 1'b0, 3'd0);
    applyCycle(1'b1, makeWord(fnAdd, 2'd0, 2'd1, 2'd0, 3'b000, 2'd0, 2'd0, 4'd0, 1'b1, 1'b0),
               '0, 1'b0, 3'd0);
    applyCycle(1'b1, makeWord(fnSub, 2'd0, 2'd1, 2'd0, 3'b000, 2'd0, 2'd0, 4'd0, 1'b1, 1'b0),
               '0, 1'b0, 3'd0);
    applyCycle(1'b1, makeWord(fnAdd, 2'd0, 2'd1, 2'd0, 3'b000, 2'd0, 2'd0, 4'd0, 1'b0, 1'b0),
               '0, 1'b0, 3'd0);
  endtask

  // Full word of v1, then one half of v2, then read back through ADB and the EBUS
  task automatic writeFmHalf(
    input logic [0:3]            adr,
    input logic [0:`EBOX_WORD-1] v1,
    input logic [0:`EBOX_WORD-1] v2,
    input logic [0:1]            we
  );
    applyCycle(1'b1, makeWord(fnAdd, 2'd0, 2'd1, arCache, 3'b000, 2'd0, 2'd0, adr, 1'b0, 1'b0),
               v1, 1'b0, 3'd0);
    applyCycle(1'b1, makeWord(fnAdd, 2'd0, 2'd1, arCache, 3'b000, 2'd0, 2'b11, adr, 1'b0, 1'b0),
               v2, 1'b0, 3'd0);
    applyCycle(1'b1, makeWord(fnAdd, 2'd0, 2'd1, 2'd0, 3'b000, 2'd0, we, adr, 1'b0, 1'b0),
               '0, 1'b0, 3'd0);
    applyCycle(1'b1, makeWord(fnPassB, 2'd0, 2'd0, 2'd0, 3'b000, 2'd0, 2'd0, adr, 1'b0, 1'b0),
               '0, 1'b1, 3'd3);
  endtask

  initial begin : compare
    logic [0:73] res;
    forever begin
      @(posedge eboxClk);
      #5;
      if (checking) begin
        res = refAdder(cram);
        checkValue("ar", ar, sAr);
        checkValue("arx", arx, sArx);
        checkValue("br", br, sBr);
        checkValue("brx", brx, sBrx);
        checkValue("mq", mq, sMq);
        checkValue("ad", ad, res[2:37]);
        checkValue("adCarry", {35'd0, adCarry}, {35'd0, res[0]});
        checkValue("adOverflow", {35'd0, adOverflow}, {35'd0, res[1]});
        checkValue("ebusDriving", {35'd0, ebusDriving}, {35'd0, expDriving});
        checkValue("ebusData", ebusData, expEbus);
      end
    end
  end

  initial begin : watchdog
    #((testCycles + 50) * 40);
    $display("Timeout: the run did not reach its end in time");
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin : stimulus
    logic [0:`EBOX_WORD-1]       allOnes;
    logic [0:`EBOX_WORD-1]       mostPos;
    logic [0:`EBOX_WORD-1]       r;
    logic [0:`EBOX_CRAM_WIDTH-1] uw;
    int                          i;
    seed = 20629;
    failures = 0;
    checking = 1'b0;
    allOnes = '1;
    mostPos = {1'b0, {35{1'b1}}};
    rstN = 1'b0;
    step = 1'b0;
    cram = idleWord;
    cacheData = '0;
    ebusIn = '0;
    diagRead = 1'b0;
    diagSel = eboxPkg::diagAr;
    sAr = '0;
    sArx = '0;
    sBr = '0;
    sBrx = '0;
    sMq = '0;
    expEbus = '0;
    expDriving = 1'b0;
    repeat (5) @(posedge eboxClk);
    @(negedge eboxClk);
    rstN = 1'b1;
    checking = 1'b1;

    // Fill FM with each word written from the AR loaded one cycle before
    for (i = 0; i <= 16; i++) begin
      applyCycle(1'b1, makeWord(fnAdd, 2'd0, 2'd1, arCache, 3'b000, 2'd0,
                                (i > 0) ? 2'b11 : 2'b00, 4'(i - 1), 1'b0, 1'b0),
                 rand36(), 1'b0, 3'd0);
    end

    // Single word arithmetic and its edge cases
    loadArBr(36'd1, allOnes);
    runArith();
    loadArBr(36'd1, mostPos);
    runArith();
    loadArBr(mostPos, mostPos);
    runArith();
    loadArBr(36'd1, ~mostPos);
    runArith();
    for (i = 0; i < 3; i++) begin
      loadArBr(rand36(), rand36());
      runArith();
    end

    // Double length carry from ADX into AD
    runLong(36'd1, 36'd2, allOnes, 36'd1);
    for (i = 0; i < 3; i++) begin
      runLong(rand36(), rand36(), rand36(), rand36());
    end

    writeFmHalf(4'd3, rand36(), rand36(), 2'b10);
    writeFmHalf(4'd9, rand36(), rand36(), 2'b01);

    // MQ load, shift left with carry 1 then 0, shift right of a negative word, hold
    r = rand36();
    applyCycle(1'b1, makeWord(fnAdd, 2'd0, 2'd1, arCache, 3'b000, 2'd0, 2'd0, 4'd0, 1'b0, 1'b0),
               {3'b111, r[3:35]}, 1'b0, 3'd0);
    applyCycle(1'b1, makeWord(fnPassA, 2'd0, 2'd1, arCache, 3'b000, 2'd1, 2'd0, 4'd0, 1'b0, 1'b0),
               allOnes, 1'b0, 3'd0);
    applyCycle(1'b1, makeWord(fnInc, 2'd0, 2'd1, 2'd0, 3'b000, 2'd2, 2'd0, 4'd0, 1'b0, 1'b0),
               '0, 1'b0, 3'd0);
    applyCycle(1'b1, makeWord(fnInc, 2'd3, 2'd1, 2'd0, 3'b000, 2'd2, 2'd0, 4'd0, 1'b0, 1'b0),
               '0, 1'b0, 3'd0);
    applyCycle(1'b1, makeWord(fnAdd, 2'd0, 2'd1, 2'd0, 3'b000, 2'd3, 2'd0, 4'd0, 1'b0, 1'b0),
               '0, 1'b0, 3'd0);
    applyCycle(1'b1, makeWord(fnAdd, 2'd0, 2'd1, 2'd0, 3'b000, 2'd3, 2'd0, 4'd0, 1'b0, 1'b0),
               '0, 1'b0, 3'd0);
    applyCycle(1'b1, idleWord, '0, 1'b0, 3'd0);

    // Step low masks every load and the EBUS request
    applyCycle(1'b0, makeWord(fnPassA, 2'd0, 2'd1, arCache, 3'b111, 2'd1, 2'd3, 4'd0, 1'b0, 1'b1),
               rand36(), 1'b0, 3'd0);

    // Diagnostic reads each followed by an idle cycle
    for (i = 0; i < 8; i++) begin
      applyCycle(1'b0, idleWord, '0, 1'b1, 3'(i));
      applyCycle(1'b0, idleWord, '0, 1'b0, 3'd0);
    end
    // AD to EBUS wins over a diagnostic read
    applyCycle(1'b1, makeWord(fnAdd, 2'd0, 2'd1, 2'd0, 3'b000, 2'd0, 2'd0, 4'd0, 1'b0, 1'b1),
               '0, 1'b1, 3'd2);
    applyCycle(1'b0, idleWord, '0, 1'b0, 3'd0);

    for (i = 0; i < randomSteps; i++) begin
      r = rand36();
      uw = r[12:35];
      applyCycle(($random(seed) & 7) != 0, uw, rand36(), r[0], r[1:3]);
    end
    applyCycle(1'b0, idleWord, '0, 1'b0, 3'd0);

    @(posedge eboxClk);
    #10;
    if (failures == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+logic
logic/eboxPkg.sv
logic/cramDecode.sv
logic/fastMem.sv
logic/adderUnit.sv
logic/edpRegs.sv
logic/ebusDriver.sv
logic/eboxDataPath.sv
tests/eboxClockGen.sv
tests/eboxTb.sv

// ==== Makefile ====
TOP := eboxTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED" || { echo "test failed"; exit 1; }

clean:
	rm -rf obj_dir
